// File: design/conv_pkg.sv
`default_nettype none

package conv_pkg;

    typedef logic [31:0] addr_t;     // byte address.
    typedef logic [31:0] word_t;     // sample, coefficient and result.
    typedef logic [23:0] count_t;    // word count.
    typedef logic [3:0]  csr_addr_t;

    // register map of the slave port.
    localparam csr_addr_t CSR_CONTROL     = 4'h0;
    localparam csr_addr_t CSR_SOURCE      = 4'h1;
    localparam csr_addr_t CSR_DESTINATION = 4'h2;
    localparam csr_addr_t CSR_WORD_SIZE   = 4'h3;
    localparam csr_addr_t CSR_KERNEL      = 4'h4;

    typedef enum logic [1:0] {
        IDLE,
        LOAD_KERNEL,
        STREAM,
        DRAIN
    } engine_state_t;

endpackage

`default_nettype wire

// File: design/conv_job_if.sv
`timescale 1ns/1ns
`default_nettype none

interface conv_job_if;
    import conv_pkg::*;

    logic   go;                     // one cycle pulse.
    logic   flush;                  // one cycle pulse.
    addr_t  source_pointer;
    addr_t  destination_pointer;
    addr_t  kernel_pointer;
    count_t word_size;
    logic   busy;

    modport csr (
        output go,
        output flush,
        output source_pointer,
        output destination_pointer,
        output kernel_pointer,
        output word_size,
        input  busy
    );

    modport engine (
        input  go,
        input  flush,
        input  source_pointer,
        input  destination_pointer,
        input  kernel_pointer,
        input  word_size,
        output busy
    );

endinterface

`default_nettype wire

// File: design/conv_result_if.sv
`timescale 1ns/1ns
`default_nettype none

interface conv_result_if;
    import conv_pkg::*;

    logic  valid;                   // one strobe per result, no back-pressure.
    addr_t address;
    word_t data;
    logic  last;
    logic  done;                    // final write issued.

    modport engine (
        output valid,
        output address,
        output data,
        output last,
        input  done
    );

    modport writeback (
        input  valid,
        input  address,
        input  data,
        input  last,
        output done
    );

endinterface

`default_nettype wire

// File: design/conv_csr.sv
`timescale 1ns/1ns
`default_nettype none

module conv_csr (
    input  logic                clock,
    input  logic                clock_sreset,

    input  conv_pkg::csr_addr_t s_address,
    input  conv_pkg::word_t     s_writedata,
    output conv_pkg::word_t     s_readdata,
    input  logic                s_read,
    input  logic                s_write,
    output logic                s_waitrequest,

    conv_job_if.csr             job
);
    import conv_pkg::*;

    logic read_latency;             // second cycle of a read.
    logic control_write;

    // writes never wait, reads hold off for one cycle.
    always_comb begin
        s_waitrequest = s_write ? 1'b0 : (s_read ? ~read_latency : 1'b0);
    end

    always_comb begin
        control_write = s_write && (s_address == CSR_CONTROL);
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            read_latency <= 1'b0;
            s_readdata <= '0;
            job.go <= 1'b0;
            job.flush <= 1'b0;
            job.source_pointer <= '0;
            job.destination_pointer <= '0;
            job.kernel_pointer <= '0;
            job.word_size <= '0;
        end
        else begin
            read_latency <= read_latency ? 1'b0 : s_read;

            // flush takes precedence when both bits are written.
            job.go <= control_write && s_writedata[0] && !s_writedata[1];
            job.flush <= control_write && s_writedata[1];

            if (s_write) begin
                case (s_address)
                    CSR_SOURCE: begin
                        job.source_pointer <= s_writedata;
                    end
                    CSR_DESTINATION: begin
                        job.destination_pointer <= s_writedata;
                    end
                    CSR_WORD_SIZE: begin
                        job.word_size <= s_writedata[$bits(count_t)-1:0];
                    end
                    CSR_KERNEL: begin
                        job.kernel_pointer <= s_writedata;
                    end
                    default: begin
                    end
                endcase
            end

            if (s_read && !read_latency) begin  // captured in the wait cycle.
                case (s_address)
                    CSR_CONTROL: begin
                        s_readdata <= word_t'(job.busy);
                    end
                    CSR_SOURCE: begin
                        s_readdata <= job.source_pointer;
                    end
                    CSR_DESTINATION: begin
                        s_readdata <= job.destination_pointer;
                    end
                    CSR_WORD_SIZE: begin
                        s_readdata <= word_t'(job.word_size);
                    end
                    CSR_KERNEL: begin
                        s_readdata <= job.kernel_pointer;
                    end
                    default: begin
                        s_readdata <= '0;
                    end
                endcase
            end
        end
    end

    go_flush_exclusive: assert property (
        @(posedge clock) disable iff (clock_sreset)
        !(job.go && job.flush)
    );

endmodule

`default_nettype wire

// File: design/conv_engine.sv
`timescale 1ns/1ns
`default_nettype none

module conv_engine #(
    parameter int NUM_TAPS = 3
)
(
    input  logic            clock,
    input  logic            clock_sreset,

    output conv_pkg::addr_t rd_address,
    output logic            rd_read,
    input  conv_pkg::word_t rd_readdata,

    conv_job_if.engine      job,
    conv_result_if.engine   result
);
    import conv_pkg::*;

    engine_state_t state;

    addr_t  src_q;
    addr_t  out_ptr;                // destination of the next launched result.
    count_t size_q;
    count_t issue_count;            // reads issued in the current phase.
    count_t sample_count;           // source words received.
    count_t stream_total;

    logic   rd_valid;
    logic   rd_kernel;
    logic   kernel_in;
    logic   sample_in;
    logic   kernel_last;
    logic   window_full;
    logic   launch;

    word_t  kernel_q    [NUM_TAPS];
    word_t  window      [NUM_TAPS];
    word_t  window_next [NUM_TAPS];
    word_t  product     [NUM_TAPS];
    word_t  product_sum;

    logic   mul_valid;
    logic   mul_last;
    addr_t  mul_address;

    assign job.busy = (state != IDLE);

    always_comb begin
        stream_total = size_q + count_t'(NUM_TAPS - 1);
        kernel_in = rd_valid && rd_kernel;
        sample_in = rd_valid && !rd_kernel;
        kernel_last = (state == LOAD_KERNEL) && (issue_count == count_t'(NUM_TAPS - 1));
        window_full = (sample_count >= count_t'(NUM_TAPS - 1));
        launch = sample_in && window_full;
    end

    // window as it stands once the returning sample is shifted in.
    always_comb begin
        for (int j = 0; j < NUM_TAPS - 1; j++) begin
            window_next[j] = window[j + 1];
        end
        window_next[NUM_TAPS - 1] = rd_readdata;
    end

    always_comb begin
        product_sum = '0;
        for (int j = 0; j < NUM_TAPS; j++) begin
            product_sum = product_sum + product[j];
        end
    end

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            state <= IDLE;
            rd_read <= 1'b0;
            rd_valid <= 1'b0;
            rd_kernel <= 1'b0;
            issue_count <= '0;
            sample_count <= '0;
            mul_valid <= 1'b0;
            result.valid <= 1'b0;
        end
        else begin
            rd_valid <= rd_read && !job.flush;  // data arrives one cycle later.
            rd_kernel <= (state == LOAD_KERNEL);
            mul_valid <= launch && !job.flush;
            result.valid <= mul_valid && !job.flush;
            if (sample_in) begin
                sample_count <= sample_count + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (job.go) begin
                        issue_count <= '0;
                        sample_count <= '0;
                        rd_read <= (job.word_size != '0);
                        state <= (job.word_size == '0) ? DRAIN : LOAD_KERNEL;
                    end
                end
                LOAD_KERNEL: begin
                    if (kernel_last) begin
                        issue_count <= '0;
                        state <= STREAM;
                    end
                    else begin
                        issue_count <= issue_count + 1'b1;
                    end
                end
                STREAM: begin
                    if (issue_count == stream_total - 1'b1) begin
                        rd_read <= 1'b0;
                        state <= DRAIN;
                    end
                    else begin
                        issue_count <= issue_count + 1'b1;
                    end
                end
                DRAIN: begin
                    if (result.done || size_q == '0) begin  // empty job has no done.
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase

            if (job.flush) begin
                rd_read <= 1'b0;
                state <= IDLE;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == IDLE && job.go) begin
            src_q <= job.source_pointer;
            size_q <= job.word_size;
            out_ptr <= job.destination_pointer;
            rd_address <= job.kernel_pointer;
        end
        else begin
            if (rd_read) begin
                rd_address <= kernel_last ? src_q : rd_address + 32'd4;
            end
            if (launch) begin
                out_ptr <= out_ptr + 32'd4;
            end
        end

        if (kernel_in) begin
            for (int j = 0; j < NUM_TAPS - 1; j++) begin
                kernel_q[j] <= kernel_q[j + 1];
            end
            kernel_q[NUM_TAPS - 1] <= rd_readdata;
        end
        if (sample_in) begin
            window <= window_next;
        end

        // stage one multiplies, stage two sums.
        for (int j = 0; j < NUM_TAPS; j++) begin
            product[j] <= kernel_q[j] * window_next[j];
        end
        mul_address <= out_ptr;
        mul_last <= (sample_count == stream_total - 1'b1);

        result.data <= product_sum;
        result.address <= mul_address;
        result.last <= mul_last;
    end

    no_read_in_idle: assert property (
        @(posedge clock) disable iff (clock_sreset)
        !(rd_read && state == IDLE)
    );

    valid_only_while_busy: assert property (
        @(posedge clock) disable iff (clock_sreset)
        result.valid |-> job.busy
    );

endmodule

`default_nettype wire

// File: design/conv_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module conv_writeback (
    input  logic               clock,
    input  logic               clock_sreset,

    output conv_pkg::addr_t    wr_address,
    output conv_pkg::word_t    wr_writedata,
    output logic               wr_write,

    conv_result_if.writeback   result,

    input  logic               flush
);
    import conv_pkg::*;

    addr_t write_address;
    word_t write_data;

    always_ff @(posedge clock) begin
        if (clock_sreset) begin
            wr_write <= 1'b0;
            result.done <= 1'b0;
        end
        else begin
            // results still in flight are dropped on flush.
            wr_write <= result.valid && !flush;
            result.done <= result.valid && result.last && !flush;
        end
    end

    always_ff @(posedge clock) begin
        write_address <= result.address;
        write_data <= result.data;
    end

    assign wr_address = write_address;
    assign wr_writedata = write_data;

    write_follows_valid: assert property (
        @(posedge clock) disable iff (clock_sreset)
        (wr_write || result.done) |-> $past(result.valid)
    );

endmodule

`default_nettype wire

// File: design/conv_top.sv
`timescale 1ns/1ns
`default_nettype none

module conv_top #(
    parameter int NUM_TAPS = 3      // kernel length, 1 to 8.
)
(
    input  logic                clock,
    input  logic                clock_sreset,

    input  conv_pkg::csr_addr_t s_address,
    input  conv_pkg::word_t     s_writedata,
    output conv_pkg::word_t     s_readdata,
    input  logic                s_read,
    input  logic                s_write,
    output logic                s_waitrequest,

    output conv_pkg::addr_t     rd_address,
    output logic                rd_read,
    input  conv_pkg::word_t     rd_readdata,

    output conv_pkg::addr_t     wr_address,
    output conv_pkg::word_t     wr_writedata,
    output logic                wr_write
);

    conv_job_if    job ();
    conv_result_if result ();

    conv_csr csr (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .s_address     (s_address),
        .s_writedata   (s_writedata),
        .s_readdata    (s_readdata),
        .s_read        (s_read),
        .s_write       (s_write),
        .s_waitrequest (s_waitrequest),
        .job           (job.csr)
    );

    conv_engine #(
        .NUM_TAPS (NUM_TAPS)
    ) engine (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .rd_address   (rd_address),
        .rd_read      (rd_read),
        .rd_readdata  (rd_readdata),
        .job          (job.engine),
        .result       (result.engine)
    );

    conv_writeback writeback (
        .clock        (clock),
        .clock_sreset (clock_sreset),
        .wr_address   (wr_address),
        .wr_writedata (wr_writedata),
        .wr_write     (wr_write),
        .result       (result.writeback),
        .flush        (job.flush)
    );

endmodule

`default_nettype wire

// File: verification/conv_tb.sv
`timescale 1ns/1ns
`default_nettype none

module conv_tb;
    import conv_pkg::*;

    localparam int NUM_TAPS = 3;    // must match the DUT.

    logic      clock;
    logic      clock_sreset;
    csr_addr_t s_address;
    word_t     s_writedata;
    word_t     s_readdata;
    logic      s_read;
    logic      s_write;
    logic      s_waitrequest;
    addr_t     rd_address;
    logic      rd_read;
    word_t     rd_readdata;
    addr_t     wr_address;
    word_t     wr_writedata;
    logic      wr_write;

    integer seed;
    int     cycle_count;
    int     last_write_cycle;
    logic   read_pending;
    addr_t  read_address;

    word_t  memory [addr_t];        // sparse memory model.
    addr_t  write_log [$];

    // state of the job under test.
    count_t job_size;
    addr_t  kernel_ptr;
    addr_t  source_ptr;
    addr_t  dest_ptr;
    word_t  kernel_words [NUM_TAPS];
    word_t  sample_words [$];
    word_t  expected_words [$];
    word_t  guard_low;
    word_t  guard_high;

    conv_top #(
        .NUM_TAPS (NUM_TAPS)
    ) uut (
        .clock         (clock),
        .clock_sreset  (clock_sreset),
        .s_address     (s_address),
        .s_writedata   (s_writedata),
        .s_readdata    (s_readdata),
        .s_read        (s_read),
        .s_write       (s_write),
        .s_waitrequest (s_waitrequest),
        .rd_address    (rd_address),
        .rd_read       (rd_read),
        .rd_readdata   (rd_readdata),
        .wr_address    (wr_address),
        .wr_writedata  (wr_writedata),
        .wr_write      (wr_write)
    );

    initial begin
        clock = 1'b0;
    end

    always #50 clock = ~clock;

    function automatic word_t random_word();
        random_word = $random(seed);
    endfunction

    function automatic word_t memory_word(input addr_t address);
        if (memory.exists(address)) begin
            memory_word = memory[address];
        end
        else begin
            memory_word = address ^ 32'h5a5a_a5a5;  // unwritten words follow the address.
        end
    endfunction

    // write side of the memory model.
    always @(posedge clock) begin
        if (wr_write) begin
            memory[wr_address] = wr_writedata;
            write_log.push_back(wr_address);
            last_write_cycle = cycle_count;
        end
        cycle_count = cycle_count + 1;
    end

    // read data returns one cycle after the strobe.
    always @(posedge clock) begin
        read_pending = rd_read;
        read_address = rd_address;
        #10;
        if (read_pending) begin
            rd_readdata = memory_word(read_address);
        end
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string test, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string test, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %0d actual %0d", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic csr_write(input csr_addr_t address, input word_t data);
        @(posedge clock);
        #10;
        s_address = address;
        s_writedata = data;
        s_write = 1'b1;
        @(posedge clock);
        #10;
        s_write = 1'b0;
    endtask

    task automatic csr_read(input csr_addr_t address, output word_t data);
        int cycles;
        @(posedge clock);
        #10;
        s_address = address;
        s_read = 1'b1;
        cycles = 0;
        @(negedge clock);
        while (s_waitrequest) begin
            cycles++;
            if (cycles > 10) begin
                $display("Timed out waiting for s_waitrequest to fall on a register read");
                abort_run();
            end
            @(negedge clock);
        end
        data = s_readdata;
        @(posedge clock);
        #10;
        s_read = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        word_t status;
        int    polls;
        polls = 0;
        csr_read(CSR_CONTROL, status);
        while (status[0]) begin
            polls++;
            if (polls > 200) begin
                $display("Timed out waiting for busy to fall in %s", name);
                abort_run();
            end
            csr_read(CSR_CONTROL, status);
        end
    endtask

    // places kernel, samples and guarded destination in memory and runs the model.
    task automatic prepare_job(input count_t size);
        word_t acc;
        job_size = size;
        kernel_ptr = 32'h1000_0000 | (random_word() & 32'h000f_fffc);
        source_ptr = 32'h2000_0000 | (random_word() & 32'h000f_fffc);
        dest_ptr = 32'h3000_0010 + (random_word() & 32'h000f_fffc);
        sample_words.delete();
        expected_words.delete();
        for (int j = 0; j < NUM_TAPS; j++) begin
            kernel_words[j] = random_word();
            memory[kernel_ptr + 4 * j] = kernel_words[j];
        end
        for (int i = 0; i < size + NUM_TAPS - 1; i++) begin
            sample_words.push_back(random_word());
            memory[source_ptr + 4 * i] = sample_words[i];
        end
        for (int n = 0; n < size; n++) begin
            acc = '0;
            for (int j = 0; j < NUM_TAPS; j++) begin
                acc = acc + kernel_words[j] * sample_words[n + j];
            end
            expected_words.push_back(acc);
        end
        for (int n = 0; n < size + 2; n++) begin
            memory[dest_ptr - 4 + 4 * n] = random_word();  // one guard word on each side.
        end
        guard_low = memory[dest_ptr - 4];
        guard_high = memory[dest_ptr + 4 * addr_t'(size)];
    endtask

    task automatic program_job();
        csr_write(CSR_SOURCE, source_ptr);
        csr_write(CSR_DESTINATION, dest_ptr);
        csr_write(CSR_KERNEL, kernel_ptr);
        csr_write(CSR_WORD_SIZE, word_t'(job_size));
        write_log.delete();
        csr_write(CSR_CONTROL, 32'd1);
    endtask

    task automatic check_job(input string name);
        addr_t limit;
        limit = dest_ptr + 4 * addr_t'(job_size);
        check_count({name, " write count"}, job_size, count_t'(write_log.size()));
        foreach (write_log[i]) begin
            if (write_log[i] < dest_ptr || write_log[i] >= limit) begin
                $display("%s wrote outside its destination range at %h", name, write_log[i]);
                abort_run();
            end
        end
        for (int n = 0; n < job_size; n++) begin
            check_word($sformatf("%s result %0d", name, n), expected_words[n],
                       memory[dest_ptr + 4 * n]);
        end
        check_word({name, " guard below"}, guard_low, memory[dest_ptr - 4]);
        check_word({name, " guard above"}, guard_high, memory[limit]);
    endtask

    task automatic run_job(input string name, input count_t size);
        word_t status;
        prepare_job(size);
        program_job();
        csr_read(CSR_CONTROL, status);
        if (size != 0) begin
            check_word({name, " busy after go"}, 32'd1, status);
        end
        wait_idle(name);
        check_job(name);
    endtask

    task automatic check_reset_state();
        word_t data;
        repeat (10) begin
            @(posedge clock);
            #10;
            if (rd_read !== 1'b0 || wr_write !== 1'b0) begin
                $display("memory strobe active after reset");
                abort_run();
            end
        end
        for (int a = 0; a <= CSR_KERNEL; a++) begin
            csr_read(csr_addr_t'(a), data);
            check_word($sformatf("reset value of register %0d", a), 32'd0, data);
        end
    endtask

    task automatic check_register_readback();
        csr_addr_t addresses [4];
        word_t     values [4];
        word_t     data;
        addresses[0] = CSR_SOURCE;
        addresses[1] = CSR_DESTINATION;
        addresses[2] = CSR_KERNEL;
        addresses[3] = CSR_WORD_SIZE;
        for (int i = 0; i < 4; i++) begin
            values[i] = random_word();
            csr_write(addresses[i], values[i]);
        end
        for (int i = 0; i < 4; i++) begin
            csr_read(addresses[i], data);
            if (addresses[i] == CSR_WORD_SIZE) begin
                check_count("word size read-back", count_t'(values[i]), count_t'(data));
                check_word("word size upper bits", word_t'(count_t'(values[i])), data);
            end
            else begin
                check_word($sformatf("read-back of register %0d", addresses[i]), values[i], data);
            end
        end
    endtask

    task automatic check_go_while_busy();
        word_t status;
        prepare_job(count_t'(14 + random_word() % 7));
        program_job();
        csr_read(CSR_CONTROL, status);
        check_word("go while busy, busy after go", 32'd1, status);
        csr_write(CSR_DESTINATION, 32'h3800_0000);
        csr_write(CSR_WORD_SIZE, 32'd3);
        csr_write(CSR_CONTROL, 32'd1);   // must be ignored.
        wait_idle("go while busy");
        check_job("go while busy");
    endtask

    task automatic check_flush();
        word_t status;
        int    cycles;
        int    flush_cycle;
        prepare_job(count_t'(18));
        program_job();
        cycles = 0;
        while (write_log.size() < 2) begin
            @(posedge clock);
            #10;
            cycles++;
            if (cycles > 100) begin
                $display("Timed out waiting for the first writes of the job to be flushed");
                abort_run();
            end
        end
        csr_write(CSR_CONTROL, 32'd2);
        flush_cycle = cycle_count;
        csr_read(CSR_CONTROL, status);
        check_word("busy after flush", 32'd0, status);
        repeat (5) @(posedge clock);
        #10;
        if (last_write_cycle > flush_cycle + 1) begin
            $display("a write occurred more than two cycles after the flush");
            abort_run();
        end
        if (write_log.size() >= job_size) begin
            $display("flush did not cut the job short");
            abort_run();
        end
        run_job("job after flush", count_t'(random_word() % 21));
    endtask

    initial begin
        seed = 19249;
        cycle_count = 0;
        last_write_cycle = 0;
        clock_sreset = 1'b1;
        s_address = '0;
        s_writedata = '0;
        s_read = 1'b0;
        s_write = 1'b0;
        rd_readdata = '0;
        repeat (5) @(posedge clock);
        #10;
        clock_sreset = 1'b0;

        check_reset_state();
        check_register_readback();
        run_job("empty job", count_t'(0));
        for (int k = 0; k < 6; k++) begin
            run_job($sformatf("job %0d", k), count_t'(random_word() % 21));
        end
        check_go_while_busy();
        check_flush();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/conv_pkg.sv
design/conv_job_if.sv
design/conv_result_if.sv
design/conv_csr.sv
design/conv_engine.sv
design/conv_writeback.sv
design/conv_top.sv
verification/conv_tb.sv

// File: Bender.yml
package:
  name: conv_accel

sources:
  - files:
      - design/conv_pkg.sv
      - design/conv_job_if.sv
      - design/conv_result_if.sv
      - design/conv_csr.sv
      - design/conv_engine.sv
      - design/conv_writeback.sv
      - design/conv_top.sv
  - target: test
    files:
      - verification/conv_tb.sv
